//--- compile.f
source/alu_pkg.sv
source/queue_pkg.sv
source/op_capture.sv
source/op_fifo.sv
source/prim_alu.sv
source/prim_top.sv
test/prim_props.sv
test/prim_tb.sv

//--- source/alu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Datapath definitions for the primitive operation unit.
// Holds the operand widths, the opcode encoding and the packed
// command record that moves from capture through the queue.
// Import it wherever operands or opcodes are handled.
// ~~~~~~~~~~~~~~~~~~~~

package alu_pkg;

  localparam int data_w = 32;            // Operand and result width.
  localparam int half_w = data_w / 2;    // Slice and cat halves.
  localparam int op_w   = 4;

  typedef logic [data_w-1:0] data_t;
  typedef logic [half_w-1:0] half_t;
  typedef logic [op_w-1:0]   opcode_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // Opcode encoding
  // ~~~~~~~~~~~~~~~~~~~~
  localparam opcode_t op_not       = 4'd0;
  localparam opcode_t op_and       = 4'd1;
  localparam opcode_t op_or        = 4'd2;
  localparam opcode_t op_xor       = 4'd3;
  localparam opcode_t op_sub       = 4'd4;
  localparam opcode_t op_lsh       = 4'd5;
  localparam opcode_t op_rsh       = 4'd6;
  localparam opcode_t op_gt        = 4'd7;   // Comparisons also set the flag.
  localparam opcode_t op_lt        = 4'd8;
  localparam opcode_t op_eq        = 4'd9;
  localparam opcode_t op_neq       = 4'd10;
  localparam opcode_t op_ge        = 4'd11;
  localparam opcode_t op_le        = 4'd12;
  localparam opcode_t op_mux       = 4'd13;  // Selects on the compare flag.
  localparam opcode_t op_slice_pad = 4'd14;
  localparam opcode_t op_cat       = 4'd15;

  // Capture rejects anything above this code.
  localparam opcode_t op_last = 4'd14;

  // Command record, opcode in the top bits then left and right.
  localparam int cmd_w = op_w + 2 * data_w;

  typedef logic [cmd_w-1:0] cmd_t;

endpackage

//--- source/op_capture.sv
// ~~~~~~~~~~~~~~~~~~~~
// Command capture stage.
// Registers each strobed command, then in the following cycle
// either pushes it into the queue or flags it as illegal or
// dropped. One command can be decided every cycle.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module op_capture
  import alu_pkg::*;
  import queue_pkg::*;
(
  input  logic    clk,
  input  logic    reset,

  input  logic    cmd_valid,
  input  opcode_t cmd_op,
  input  data_t   cmd_left,
  input  data_t   cmd_right,

  input  logic    full,
  output logic    push,
  output cmd_t    push_cmd,

  output logic    cmd_illegal,
  output logic    cmd_dropped,
  output logic    pending
);

  capture_state_t state;

  opcode_t op_q;
  data_t   left_q;
  data_t   right_q;
  logic    legal;

  // ~~~~~~~~~~~~~~~~~~~~
  // State
  // ~~~~~~~~~~~~~~~~~~~~
  // The port named pending hides the enum value, so states are
  // referenced through the package.
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= queue_pkg::idle;
    end else if (cmd_valid) begin
      state <= queue_pkg::pending;     // A new strobe replaces the decided one.
    end else begin
      state <= queue_pkg::idle;
    end
  end

  // Command payload.
  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      op_q    <= cmd_op;
      left_q  <= cmd_left;
      right_q <= cmd_right;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Decision
  // ~~~~~~~~~~~~~~~~~~~~
  assign pending = (state == queue_pkg::pending);
  assign legal   = (op_q <= op_last);

  assign push        = pending && legal && !full;
  assign cmd_illegal = pending && !legal;
  assign cmd_dropped = pending && legal && full;    // Queue has no room.

  assign push_cmd = {op_q, left_q, right_q};

endmodule

//--- source/op_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~
// Command queue.
// Circular store of command records between capture and the
// primitive unit. The oldest record is always shown at the
// head. Push and pop in one cycle are both taken, even when full.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module op_fifo
  import alu_pkg::*;
  import queue_pkg::*;
(
  input  logic clk,
  input  logic reset,

  input  logic push,
  input  cmd_t push_cmd,

  input  logic pop,
  output cmd_t head_cmd,

  output logic full,
  output logic empty
);

  cmd_t mem [fifo_depth];

  ptr_t   wr_ptr;
  ptr_t   rd_ptr;
  count_t count;

  logic do_push;
  logic do_pop;

  assign do_pop  = pop && !empty;
  assign do_push = push && (!full || do_pop);   // A pop frees the slot.

  // ~~~~~~~~~~~~~~~~~~~~
  // Storage
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_cmd;
    end
  end

  assign head_cmd = mem[rd_ptr];

  // ~~~~~~~~~~~~~~~~~~~~
  // Pointers and count
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + ptr_t'(1);
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + ptr_t'(1);
      end
      if (do_push && !do_pop) begin
        count <= count + count_t'(1);
      end else if (do_pop && !do_push) begin
        count <= count - count_t'(1);
      end
    end
  end

  assign full  = (count == count_t'(fifo_depth));
  assign empty = (count == '0);

endmodule

//--- source/prim_alu.sv
// ~~~~~~~~~~~~~~~~~~~~
// Primitive operation unit.
// Pops one command per cycle from the queue head, evaluates it
// with the standard primitive operators and registers the result.
// Comparisons also update a flag that a later mux selects on.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module prim_alu
  import alu_pkg::*;
(
  input  logic  clk,
  input  logic  reset,

  input  logic  empty,
  input  cmd_t  head_cmd,
  input  logic  result_hold,
  output logic  pop,

  output logic  result_valid,
  output data_t result_data
);

  opcode_t head_op;
  data_t   head_left;
  data_t   head_right;
  half_t   left_lo;
  half_t   right_lo;

  data_t   alu_out;
  logic    cmp_bit;
  logic    is_cmp;
  logic    cmp_flag;

  // Hold stalls the head in the queue.
  assign pop = !empty && !result_hold;

  assign {head_op, head_left, head_right} = head_cmd;

  assign left_lo  = head_left[half_w-1:0];
  assign right_lo = head_right[half_w-1:0];

  // ~~~~~~~~~~~~~~~~~~~~
  // Operators
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    alu_out = '0;
    cmp_bit = 1'b0;
    is_cmp  = 1'b0;
    case (head_op)
      op_not: alu_out = ~head_left;
      op_and: alu_out = head_left & head_right;
      op_or:  alu_out = head_left | head_right;
      op_xor: alu_out = head_left ^ head_right;
      op_sub: alu_out = head_left - head_right;
      op_lsh: alu_out = head_left << head_right;    // Amounts past the width give zero.
      op_rsh: alu_out = head_left >> head_right;
      op_gt: begin
        cmp_bit = head_left > head_right;
        is_cmp  = 1'b1;
      end
      op_lt: begin
        cmp_bit = head_left < head_right;
        is_cmp  = 1'b1;
      end
      op_eq: begin
        cmp_bit = head_left == head_right;
        is_cmp  = 1'b1;
      end
      op_neq: begin
        cmp_bit = head_left != head_right;
        is_cmp  = 1'b1;
      end
      op_ge: begin
        cmp_bit = head_left >= head_right;
        is_cmp  = 1'b1;
      end
      op_le: begin
        cmp_bit = head_left <= head_right;
        is_cmp  = 1'b1;
      end
      op_mux:       alu_out = cmp_flag ? head_left : head_right;
      op_slice_pad: alu_out = {{(data_w - half_w){1'b0}}, left_lo};
      op_cat:       alu_out = {left_lo, right_lo};
      default:      alu_out = '0;
    endcase

    // Compare result padded out to a full word.
    if (is_cmp) begin
      alu_out = {{(data_w - 1){1'b0}}, cmp_bit};
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Flag and result registers
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (reset) begin
      cmp_flag     <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= pop;
      if (pop && is_cmp) begin
        cmp_flag <= cmp_bit;           // Most recent comparison wins.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      result_data <= alu_out;
    end
  end

endmodule

//--- source/prim_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Top level of the primitive operation unit.
// Commands enter as strobes, pass through capture and the queue,
// and leave as registered results. Result_hold stalls the output
// side while the queue absorbs incoming commands.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module prim_top
  import alu_pkg::*;
(
  input  logic    clk,
  input  logic    reset,

  input  logic    cmd_valid,
  input  opcode_t cmd_op,
  input  data_t   cmd_left,
  input  data_t   cmd_right,
  input  logic    result_hold,

  output logic    result_valid,
  output data_t   result_data,
  output logic    cmd_illegal,
  output logic    cmd_dropped,
  output logic    busy
);

  logic push;
  cmd_t push_cmd;
  logic full;
  logic empty;
  logic pop;
  cmd_t head_cmd;
  logic pending;

  op_capture u_capture (
    .clk         (clk),
    .reset       (reset),
    .cmd_valid   (cmd_valid),
    .cmd_op      (cmd_op),
    .cmd_left    (cmd_left),
    .cmd_right   (cmd_right),
    .full        (full),
    .push        (push),
    .push_cmd    (push_cmd),
    .cmd_illegal (cmd_illegal),
    .cmd_dropped (cmd_dropped),
    .pending     (pending)
  );

  op_fifo u_fifo (
    .clk      (clk),
    .reset    (reset),
    .push     (push),
    .push_cmd (push_cmd),
    .pop      (pop),
    .head_cmd (head_cmd),
    .full     (full),
    .empty    (empty)
  );

  prim_alu u_alu (
    .clk          (clk),
    .reset        (reset),
    .empty        (empty),
    .head_cmd     (head_cmd),
    .result_hold  (result_hold),
    .pop          (pop),
    .result_valid (result_valid),
    .result_data  (result_data)
  );

  assign busy = pending || !empty;    // Work captured or still queued.

endmodule

//--- source/queue_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Queue and capture definitions.
// Depth of the command queue, its pointer and count types,
// and the states of the capture stage.
// ~~~~~~~~~~~~~~~~~~~~

package queue_pkg;

  localparam int fifo_depth = 8;                 // Commands held while stalled.
  localparam int ptr_w      = $clog2(fifo_depth);

  // Depth is a power of two, so pointers wrap on their own.
  typedef logic [ptr_w-1:0] ptr_t;

  // One bit wider than a pointer so a full queue can be counted.
  typedef logic [ptr_w:0] count_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // Capture stage
  // ~~~~~~~~~~~~~~~~~~~~
  typedef enum logic {
    idle,      // Nothing registered.
    pending    // Command registered, decided this cycle.
  } capture_state_t;

endpackage

//--- test/prim_props.sv
// ~~~~~~~~~~~~~~~~~~~~
// Concurrent assertions for the primitive operation unit.
// Bound into every prim_top instance. Each failure raises $error
// and bumps fail_count, which the testbench reads at the end.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module prim_props
  import alu_pkg::*;
(
  input logic    clk,
  input logic    reset,
  input logic    cmd_valid,
  input opcode_t cmd_op,
  input logic    result_hold,
  input logic    result_valid,
  input logic    cmd_illegal,
  input logic    cmd_dropped,
  input logic    busy
);

  int fail_count = 0;

  // Idle unit and no stall, so the result follows two edges after capture.
  latency_on_idle: assert property (@(posedge clk) disable iff (reset)
    (cmd_valid && (cmd_op <= op_last) && !busy && !result_hold)
      ##1 !result_hold ##1 !result_hold |=> result_valid)
  else begin
    $error("legal command on an idle unit did not give its result two cycles later");
    fail_count++;
  end

  // A flag answers the command strobed one edge earlier, never both at once,
  // and only an opcode above op_last raises cmd_illegal.
  flags_match_command: assert property (@(posedge clk) disable iff (reset)
    (cmd_illegal || cmd_dropped) |->
      ($past(cmd_valid) && !(cmd_illegal && cmd_dropped)
       && (cmd_illegal == ($past(cmd_op) > op_last))))
  else begin
    $error("cmd_illegal or cmd_dropped did not match the command strobed before it");
    fail_count++;
  end

  no_result_on_hold: assert property (@(posedge clk) disable iff (reset)
    result_hold |=> !result_valid)
  else begin
    $error("a result left the unit while result_hold was high");
    fail_count++;
  end

  quiet_after_reset: assert property (@(posedge clk)
    reset |=> (!result_valid && !cmd_illegal && !cmd_dropped && !busy))
  else begin
    $error("outputs were not quiet after a reset edge");
    fail_count++;
  end

endmodule

bind prim_top prim_props u_props (
  .clk          (clk),
  .reset        (reset),
  .cmd_valid    (cmd_valid),
  .cmd_op       (cmd_op),
  .result_hold  (result_hold),
  .result_valid (result_valid),
  .cmd_illegal  (cmd_illegal),
  .cmd_dropped  (cmd_dropped),
  .busy         (busy)
);

//--- test/prim_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the primitive operation unit.
// Drives commands into prim_top, predicts each result with a
// reference model and checks it as it leaves. Six tests run in
// sequence, each reporting one line, then a summary closes the run.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module prim_tb
  import alu_pkg::*;
  import queue_pkg::*;
();

  localparam int timeout_cycles = 2000;   // Roughly four times the full sequence.

  localparam int cls_none    = 0;
  localparam int cls_result  = 1;
  localparam int cls_illegal = 2;
  localparam int cls_drop    = 3;

  logic    clk;
  logic    reset;
  logic    cmd_valid;
  opcode_t cmd_op;
  data_t   cmd_left;
  data_t   cmd_right;
  logic    result_hold;
  logic    result_valid;
  data_t   result_data;
  logic    cmd_illegal;
  logic    cmd_dropped;
  logic    busy;

  data_t exp_q[$];           // Expected results in issue order.
  int    result_cycles[$];
  data_t head_exp;
  logic  model_flag;
  int    cmd_class;
  int    prev_class;
  logic  prev_valid;
  int    cyc = 0;
  int    results_seen = 0;
  int    last_capture_cyc = 0;
  int    errors = 0;
  int    test_num = 0;
  int    test_errors_base = 0;

  prim_top dut (
    .clk          (clk),
    .reset        (reset),
    .cmd_valid    (cmd_valid),
    .cmd_op       (cmd_op),
    .cmd_left     (cmd_left),
    .cmd_right    (cmd_right),
    .result_hold  (result_hold),
    .result_valid (result_valid),
    .result_data  (result_data),
    .cmd_illegal  (cmd_illegal),
    .cmd_dropped  (cmd_dropped),
    .busy         (busy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // ~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic model_step(input opcode_t op, input data_t l, input data_t r,
                            output data_t res);
    logic cmp;
    bit   is_cmp;
    res    = '0;
    cmp    = 1'b0;
    is_cmp = 1'b1;
    case (op)
      op_gt:   cmp = (l > r);
      op_lt:   cmp = (l < r);
      op_eq:   cmp = (l == r);
      op_neq:  cmp = (l != r);
      op_ge:   cmp = (l >= r);
      op_le:   cmp = (l <= r);
      default: is_cmp = 1'b0;
    endcase
    if (is_cmp) begin
      model_flag = cmp;
      res        = data_t'(cmp);    // Zero padded to a word.
    end else begin
      case (op)
        op_not:       res = ~l;
        op_and:       res = l & r;
        op_or:        res = l | r;
        op_xor:       res = l ^ r;
        op_sub:       res = l + ~r + data_t'(1);
        op_lsh:       res = (r >= data_w) ? '0 : l << r[$clog2(data_w)-1:0];
        op_rsh:       res = (r >= data_w) ? '0 : l >> r[$clog2(data_w)-1:0];
        op_mux:       res = model_flag ? l : r;
        op_slice_pad: res = data_t'(l[half_w-1:0]);
        default:      res = '0;
      endcase
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Output monitor
  // ~~~~~~~~~~~~~~~~~~~~
  always @(negedge clk) begin
    if (!reset) begin
      assert (cmd_illegal == (prev_valid && prev_class == cls_illegal)) else begin
        $display("Fail %0t: cmd_illegal is %b against the issued command", $time, cmd_illegal);
        errors++;
      end
      assert (cmd_dropped == (prev_valid && prev_class == cls_drop)) else begin
        $display("Fail %0t: cmd_dropped is %b against the issued command", $time, cmd_dropped);
        errors++;
      end
      if (result_valid) begin
        results_seen++;
        result_cycles.push_back(cyc);
        if (exp_q.size() == 0) begin
          $display("Fail %0t: result %h with no command outstanding", $time, result_data);
          errors++;
        end else begin
          head_exp = exp_q.pop_front();
          assert (result_data == head_exp) else begin
            $display("Fail %0t: result %h, expected %h", $time, result_data, head_exp);
            errors++;
          end
        end
      end
      if (cmd_valid) last_capture_cyc = cyc + 1;   // Edge that samples it.
    end
    prev_valid <= cmd_valid && !reset;
    prev_class <= cmd_class;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Stimulus helpers
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic send_cmd(input opcode_t op, input data_t l, input data_t r, input bit drop);
    data_t res;
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd_op    <= op;
    cmd_left  <= l;
    cmd_right <= r;
    if (op > op_last) begin
      cmd_class <= cls_illegal;
    end else if (drop) begin
      cmd_class <= cls_drop;
    end else begin
      cmd_class <= cls_result;
      model_step(op, l, r, res);
      exp_q.push_back(res);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      cmd_valid <= 1'b0;
      cmd_class <= cls_none;
    end
  endtask

  task automatic drain();
    idle(1);
    while (exp_q.size() != 0) idle(1);
    idle(2);
  endtask

  task automatic set_hold(input bit v);
    @(posedge clk);
    result_hold <= v;
    cmd_valid   <= 1'b0;
    cmd_class   <= cls_none;
  endtask

  task automatic apply_reset(input int n);
    @(posedge clk);
    reset       <= 1'b1;
    cmd_valid   <= 1'b0;
    cmd_class   <= cls_none;
    result_hold <= 1'b0;
    exp_q.delete();
    model_flag = 1'b0;
    repeat (n) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic expect_true(input bit cond, input string msg);
    assert (cond) else begin
      $display("Fail %0t: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    test_num++;
    $display("test %0d %s done, %0d errors", test_num, name, errors - test_errors_base);
    test_errors_base = errors;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~
  initial begin
    int base;
    void'($urandom(32'h525f_2621));
    reset       = 1'b1;
    cmd_valid   = 1'b0;
    cmd_op      = '0;
    cmd_left    = '0;
    cmd_right   = '0;
    result_hold = 1'b0;
    cmd_class   = cls_none;
    model_flag  = 1'b0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    idle(2);

    for (int op = 0; op <= op_last; op++) begin
      send_cmd(opcode_t'(op), 32'hF000_0001, 32'h0000_0003, 1'b0);
      send_cmd(opcode_t'(op), 32'h1234_5678, 32'h8765_4321, 1'b0);
      send_cmd(opcode_t'(op), 32'hDEAD_BEEF, 32'hDEAD_BEEF, 1'b0);
      send_cmd(opcode_t'(op), 32'hCAFE_0000, 32'd32, 1'b0);
      send_cmd(opcode_t'(op), 32'hFFFF_FFFF, 32'd31, 1'b0);
      send_cmd(opcode_t'(op), $urandom(), 32'hFFFF_FFFF, 1'b0);
      repeat (4) send_cmd(opcode_t'(op), $urandom(), $urandom_range(0, 40), 1'b0);
      repeat (4) send_cmd(opcode_t'(op), $urandom(), $urandom(), 1'b0);
      drain();
    end
    end_test("every opcode");

    send_cmd(op_gt, 32'd9, 32'd4, 1'b0);
    send_cmd(op_mux, 32'hAAAA_0001, 32'h5555_0002, 1'b0);   // Left expected.
    send_cmd(op_le, 32'd9, 32'd4, 1'b0);
    send_cmd(op_mux, 32'hAAAA_0003, 32'h5555_0004, 1'b0);   // Right expected.
    drain();
    end_test("mux follows compare flag");

    base = results_seen;
    send_cmd(op_cat, 32'hABCD_1234, 32'h5678_9ABC, 1'b0);
    idle(4);
    expect_true(results_seen == base, "illegal opcode produced a result");
    send_cmd(op_and, $urandom(), $urandom(), 1'b0);
    send_cmd(4'd15, $urandom(), $urandom(), 1'b0);
    send_cmd(op_or, $urandom(), $urandom(), 1'b0);
    drain();
    expect_true(results_seen == base + 2, "legal neighbours of an illegal opcode were lost");
    end_test("illegal opcode");

    set_hold(1'b1);
    base = results_seen;
    repeat (fifo_depth) begin
      send_cmd(opcode_t'($urandom_range(0, op_last)), $urandom(), $urandom(), 1'b0);
    end
    send_cmd(op_xor, $urandom(), $urandom(), 1'b1);
    idle(6);
    expect_true(results_seen == base, "results appeared while result_hold was high");
    @(negedge clk);
    expect_true(busy, "busy is low with commands held in the queue");
    set_hold(1'b0);
    drain();
    expect_true(results_seen == base + fifo_depth, "wrong number of results after the stall");
    end_test("back-pressure");

    base = results_seen;
    result_cycles.delete();
    send_cmd(op_sub, $urandom(), $urandom(), 1'b0);
    idle(1);
    while (results_seen < base + 1) idle(1);
    expect_true(result_cycles[0] - last_capture_cyc == 2, "single command latency is not 2");
    drain();
    result_cycles.delete();
    repeat (6) send_cmd(opcode_t'($urandom_range(0, op_last)), $urandom(), $urandom(), 1'b0);
    drain();
    expect_true(result_cycles.size() == 6, "burst did not give six results");
    if (result_cycles.size() == 6) begin
      expect_true(result_cycles[5] - result_cycles[0] == 5, "burst results not one per cycle");
    end
    end_test("latency and throughput");

    send_cmd(op_ge, 32'd7, 32'd7, 1'b0);     // Leaves the flag set.
    drain();
    set_hold(1'b1);
    repeat (4) send_cmd(opcode_t'($urandom_range(0, op_last)), $urandom(), $urandom(), 1'b0);
    idle(2);
    apply_reset(5);
    @(negedge clk);
    expect_true(!busy && !result_valid && !cmd_illegal && !cmd_dropped,
                "outputs not cleared by a reset during traffic");
    base = results_seen;
    send_cmd(op_mux, 32'h1111_1111, 32'h2222_2222, 1'b0);
    send_cmd(op_lt, 32'd1, 32'd2, 1'b0);
    send_cmd(op_mux, 32'h3333_3333, 32'h4444_4444, 1'b0);
    drain();
    expect_true(results_seen == base + 3, "commands after reset were not all handled");
    end_test("reset mid-stream");

    $display("%0d tests, %0d check failures, %0d assertion failures",
             test_num, errors, dut.u_props.fail_count);
    if (errors == 0 && dut.u_props.fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    while (cyc < timeout_cycles) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule
